/* emesh_pkg.sv */
// emesh packet format shared by the link decoder and the top level
`default_nettype none

package emesh_pkg;

   // address and data widths of the mesh
   localparam int emesh_aw = 32;
   localparam int emesh_dw = 32;

   // one mesh transaction of 103 bits with the msb first
   //   write     1 for a write or a read reply
   //   datamode  transfer size code
   //   ctrlmode  routing and special modes
   //   dstaddr   target address with the chip id in the top bits
   //   data      write data or read result
   //   srcaddr   return address for reads
   typedef struct packed {
      logic                write;
      logic [1:0]          datamode;
      logic [3:0]          ctrlmode;
      logic [emesh_aw-1:0] dstaddr;
      logic [emesh_dw-1:0] data;
      logic [emesh_aw-1:0] srcaddr;
   } emesh_packet_t;

   // dstaddr layout used by the decoder
   //   31:20  chip id
   //   19:16  register group
   //   10:8   bank select
   //   7:2    register offset

   // a read reply carries the register value in data,
   // with dstaddr and srcaddr swapped from the request

endpackage

`default_nettype wire

/* ecfg_map_pkg.sv */
// register map of the link configuration port, with bank strobe bus and bank outputs
`default_nettype none

package ecfg_map_pkg;

   // chip identifier matched against dstaddr[31:20]
   localparam logic [11:0] chip_id = 12'h810;

   // register groups in dstaddr[19:16]
   localparam logic [3:0] egroup_mmr = 4'hf;
   localparam logic [3:0] egroup_mmu = 4'he;
   localparam logic [3:0] egroup_rr  = 4'hd;

   // bank selects in dstaddr[10:8]
   // the rx side uses the odd config select
   localparam logic [2:0] cfg_sel_tx = 3'b010;
   localparam logic [2:0] dma_sel    = 3'b101;

   // configuration bank offsets, dstaddr[7:2]
   localparam logic [5:0] reg_etx_cfg     = 6'd0;
   localparam logic [5:0] reg_etx_gpio    = 6'd2;
   localparam logic [5:0] reg_etx_version = 6'd3;

   // dma bank offsets, dstaddr[7:2]
   localparam logic [5:0] reg_dma_cfg     = 6'd0;
   localparam logic [5:0] reg_dma_count   = 6'd1;
   localparam logic [5:0] reg_dma_stride  = 6'd2;
   localparam logic [5:0] reg_dma_srcaddr = 6'd3;
   localparam logic [5:0] reg_dma_dstaddr = 6'd4;

   // fixed words
   localparam logic [31:0] etx_version_value = 32'h0001_0203;
   localparam logic [31:0] etx_cfg_reset     = 32'h0000_0010;

   // strobe bus from the decoder to both banks
   typedef struct packed {
      logic        cfg_en;
      logic        dma_en;
      logic        we;
      logic [5:0]  addr;
      logic [31:0] din;
   } mi_bus_t;

   // configuration bank outputs
   typedef struct packed {
      logic [31:0] cfg;
      logic [31:0] gpio;
   } etx_cfg_t;

   // dma descriptor outputs
   typedef struct packed {
      logic [31:0] cfg;
      logic [31:0] count;
      logic [31:0] stride;
      logic [31:0] srcaddr;
      logic [31:0] dstaddr;
   } dma_cfg_t;

endpackage

`default_nettype wire

/* ecfg_if.sv */
// config packet decoder: strobes the register banks and returns read replies or forwards
`default_nettype none
`timescale 1ns/1ps

module ecfg_if #(
   parameter bit rx_side = 1'b0
) (
   input  wire                           clk,
   input  wire                           nreset,
   input  wire                           access_in,
   input  wire emesh_pkg::emesh_packet_t packet_in,
   input  wire                           wait_in,
   output ecfg_map_pkg::mi_bus_t         mi,
   input  wire [31:0]                    cfg_dout,
   input  wire [31:0]                    dma_dout,
   output logic                          access_out,
   output emesh_pkg::emesh_packet_t      packet_out
);

   logic [emesh_pkg::emesh_aw-1:0] dstaddr;
   logic [3:0]                     group;
   logic                           match;
   logic                           cfg_en;
   logic                           dma_en;
   logic                           mi_en;
   logic                           mi_rd;
   logic                           forward;
   logic [emesh_pkg::emesh_dw-1:0] readback;
   emesh_pkg::emesh_packet_t       reply;

   assign dstaddr = packet_in.dstaddr;
   assign group   = dstaddr[19:16];

   // packet addressed to this chip
   assign match = access_in & (dstaddr[31:20] == ecfg_map_pkg::chip_id);

   // config bank, select low bit picks tx or rx
   assign cfg_en = match
                 & (group == ecfg_map_pkg::egroup_mmr)
                 & (dstaddr[10:8] == (ecfg_map_pkg::cfg_sel_tx | {2'b00, rx_side}));

   // dma bank, bit 5 splits the tx and rx descriptors
   assign dma_en = match
                 & (group == ecfg_map_pkg::egroup_mmr)
                 & (dstaddr[10:8] == ecfg_map_pkg::dma_sel)
                 & (dstaddr[5] == rx_side);

   assign mi_en = cfg_en | dma_en;
   assign mi_rd = mi_en & ~packet_in.write;

   // other groups of this chip go on toward the receive side
   assign forward = match & ~mi_en
                  & ((group == ecfg_map_pkg::egroup_rr)
                  |  (group == ecfg_map_pkg::egroup_mmr)
                  |  (group == ecfg_map_pkg::egroup_mmu));

   // strobe bus to both banks
   always_comb
   begin
      mi.cfg_en = cfg_en;
      mi.dma_en = dma_en;
      mi.we     = mi_en & packet_in.write;
      mi.addr   = dstaddr[7:2];
      mi.din    = packet_in.data;
   end

   // idle banks drive zero, so OR is enough
   assign readback = cfg_dout | dma_dout;

   // reply goes back to the requester
   always_comb
   begin
      reply         = packet_in;
      reply.write   = 1'b1;
      reply.dstaddr = packet_in.srcaddr;
      reply.srcaddr = packet_in.dstaddr;
      reply.data    = readback;
   end

   // output stage holds while wait_in is high
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         access_out <= 1'b0;
      else if (!wait_in)
         access_out <= mi_rd | forward;
   end

   always_ff @(posedge clk)
   begin
      if (!wait_in)
         packet_out <= forward ? packet_in : reply;
   end

endmodule

`default_nettype wire

/* ecfg_cfg_regs.sv */
// transmit configuration bank: cfg and gpio registers plus read-only version word
`default_nettype none
`timescale 1ns/1ps

module ecfg_cfg_regs (
   input  wire                        clk,
   input  wire                        nreset,
   input  wire ecfg_map_pkg::mi_bus_t mi,
   output logic [31:0]                cfg_dout,
   output ecfg_map_pkg::etx_cfg_t     etx_cfg
);

   logic wr_en;

   // write strobe for this bank only
   assign wr_en = mi.cfg_en & mi.we;

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         etx_cfg.cfg  <= ecfg_map_pkg::etx_cfg_reset;
         etx_cfg.gpio <= '0;
      end
      else if (wr_en)
      begin
         case (mi.addr)
            ecfg_map_pkg::reg_etx_cfg:
            begin
               etx_cfg.cfg <= mi.din;
            end
            ecfg_map_pkg::reg_etx_gpio:
            begin
               etx_cfg.gpio <= mi.din;
            end
            // version is read only, others unmapped
            default:
            begin
            end
         endcase
      end
   end

   // readback, zero when not selected
   always_comb
   begin
      cfg_dout = '0;
      if (mi.cfg_en)
      begin
         case (mi.addr)
            ecfg_map_pkg::reg_etx_cfg:
               cfg_dout = etx_cfg.cfg;
            ecfg_map_pkg::reg_etx_gpio:
               cfg_dout = etx_cfg.gpio;
            ecfg_map_pkg::reg_etx_version:
               cfg_dout = ecfg_map_pkg::etx_version_value;
            default:
               cfg_dout = '0;
         endcase
      end
   end

endmodule

`default_nettype wire

/* ecfg_dma_regs.sv */
// dma descriptor bank: five registers that set up the link dma engine
`default_nettype none
`timescale 1ns/1ps

module ecfg_dma_regs (
   input  wire                        clk,
   input  wire                        nreset,
   input  wire ecfg_map_pkg::mi_bus_t mi,
   output logic [31:0]                dma_dout,
   output ecfg_map_pkg::dma_cfg_t     dma_cfg
);

   logic wr_en;

   assign wr_en = mi.dma_en & mi.we;

   // descriptor registers all clear to zero
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         dma_cfg <= '0;
      else if (wr_en)
      begin
         case (mi.addr)
            ecfg_map_pkg::reg_dma_cfg:
               dma_cfg.cfg <= mi.din;
            ecfg_map_pkg::reg_dma_count:
               dma_cfg.count <= mi.din;
            ecfg_map_pkg::reg_dma_stride:
               dma_cfg.stride <= mi.din;
            ecfg_map_pkg::reg_dma_srcaddr:
               dma_cfg.srcaddr <= mi.din;
            ecfg_map_pkg::reg_dma_dstaddr:
               dma_cfg.dstaddr <= mi.din;
            // unmapped offsets are ignored
            default:
            begin
            end
         endcase
      end
   end

   // readback mux, zero when the bank is idle
   always_comb
   begin
      dma_dout = '0;
      if (mi.dma_en)
      begin
         case (mi.addr)
            ecfg_map_pkg::reg_dma_cfg:
               dma_dout = dma_cfg.cfg;
            ecfg_map_pkg::reg_dma_count:
               dma_dout = dma_cfg.count;
            ecfg_map_pkg::reg_dma_stride:
               dma_dout = dma_cfg.stride;
            ecfg_map_pkg::reg_dma_srcaddr:
               dma_dout = dma_cfg.srcaddr;
            ecfg_map_pkg::reg_dma_dstaddr:
               dma_dout = dma_cfg.dstaddr;
            default:
               dma_dout = '0;
         endcase
      end
   end

endmodule

`default_nettype wire

/* elink_cfg_top.sv */
// link transmit config port: decoder with the configuration and dma register banks
`default_nettype none
`timescale 1ns/1ps

module elink_cfg_top (
   input  wire                            clk,
   input  wire                            nreset,
   input  wire                            access_in,
   input  wire emesh_pkg::emesh_packet_t  packet_in,
   input  wire                            wait_in,
   output wire                            access_out,
   output wire emesh_pkg::emesh_packet_t  packet_out,
   output wire ecfg_map_pkg::etx_cfg_t    etx_cfg,
   output wire ecfg_map_pkg::dma_cfg_t    dma_cfg
);

   wire ecfg_map_pkg::mi_bus_t mi;
   wire [31:0]                 cfg_dout;
   wire [31:0]                 dma_dout;

   // transmit side decoder
   ecfg_if #(
      .rx_side (1'b0)
   ) u_if (
      .clk        (clk),
      .nreset     (nreset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_in    (wait_in),
      .mi         (mi),
      .cfg_dout   (cfg_dout),
      .dma_dout   (dma_dout),
      .access_out (access_out),
      .packet_out (packet_out)
   );

   ecfg_cfg_regs u_cfg (
      .clk      (clk),
      .nreset   (nreset),
      .mi       (mi),
      .cfg_dout (cfg_dout),
      .etx_cfg  (etx_cfg)
   );

   ecfg_dma_regs u_dma (
      .clk      (clk),
      .nreset   (nreset),
      .mi       (mi),
      .dma_dout (dma_dout),
      .dma_cfg  (dma_cfg)
   );

endmodule

`default_nettype wire

/* elink_cfg_asserts.sv */
// output stage and back-pressure assertions for the link config port
`default_nettype none
`timescale 1ns/1ps

module elink_cfg_asserts (
   input wire                           clk,
   input wire                           nreset,
   input wire                           wait_in,
   input wire                           access_out,
   input wire emesh_pkg::emesh_packet_t packet_out,
   input wire                           mi_rd,
   input wire                           forward
);

   // output valid is cleared by reset
   a_reset_quiet: assert property (@(posedge clk) !nreset |-> !access_out)
      else $error("access_out high during reset");

   // output stage frozen under wait
   a_hold: assert property (@(posedge clk) disable iff (!nreset)
      wait_in |=> ($stable(access_out) && $stable(packet_out)))
      else $error("output stage changed while wait_in was high");

   // reads and forwards would be lost under wait
   a_no_lost: assert property (@(posedge clk) disable iff (!nreset)
      wait_in |-> !(mi_rd || forward))
      else $error("read or forward arrived while wait_in was high");

endmodule

bind elink_cfg_top elink_cfg_asserts u_asserts (
   .clk        (clk),
   .nreset     (nreset),
   .wait_in    (wait_in),
   .access_out (access_out),
   .packet_out (packet_out),
   .mi_rd      (u_if.mi_rd),
   .forward    (u_if.forward)
);

`default_nettype wire

/* tb_elink_cfg.sv */
// testbench for the link config port: table driven writes, reads, forwards and drops
`default_nettype none
`timescale 1ns/1ps

module tb_elink_cfg;

   typedef enum logic [1:0] {k_reply, k_forward, k_drop, k_write} kind_t;

   typedef struct {
      string                    name;
      emesh_pkg::emesh_packet_t pkt;
      logic                     access;
      logic                     hold;
      kind_t                    kind;
      logic                     bank;
   } row_t;

   logic                         clk;
   logic                         nreset;
   logic                         access_in;
   logic                         wait_in;
   emesh_pkg::emesh_packet_t     packet_in;
   wire                          access_out;
   emesh_pkg::emesh_packet_t     packet_out;
   ecfg_map_pkg::etx_cfg_t       etx_cfg;
   ecfg_map_pkg::dma_cfg_t       dma_cfg;

   row_t                         rows[64];
   int                           nrows;
   int                           errors;
   int                           checks;
   logic [31:0]                  m_cfg;
   logic [31:0]                  m_gpio;
   logic [31:0]                  m_dma[5];

   elink_cfg_top dut (
      .clk        (clk),
      .nreset     (nreset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_in    (wait_in),
      .access_out (access_out),
      .packet_out (packet_out),
      .etx_cfg    (etx_cfg),
      .dma_cfg    (dma_cfg)
   );

   always #20 clk = ~clk;

   // dstaddr: chip, group, bank select, offset
   function automatic logic [31:0] make_addr(input logic [11:0] chip, input logic [3:0] group,
                                             input logic [2:0] sel, input logic [5:0] off);
      make_addr = {chip, group, 5'b00000, sel, off, 2'b00};
   endfunction

   // register value the banks should return
   function automatic logic [31:0] model_read(input logic bank, input logic [5:0] off);
      model_read = 32'h0;
      if (!bank)
      begin
         case (off)
            6'd0: model_read = m_cfg;
            6'd2: model_read = m_gpio;
            6'd3: model_read = 32'h0001_0203;
            default: model_read = 32'h0;
         endcase
      end
      else
      begin
         case (off)
            6'd0: model_read = m_dma[0];
            6'd1: model_read = m_dma[1];
            6'd2: model_read = m_dma[2];
            6'd3: model_read = m_dma[3];
            6'd4: model_read = m_dma[4];
            default: model_read = 32'h0;
         endcase
      end
   endfunction

   task automatic model_write(input logic bank, input logic [5:0] off, input logic [31:0] d);
      if (!bank)
      begin
         if (off == 6'd0)
            m_cfg = d;
         else if (off == 6'd2)
            m_gpio = d;
      end
      else
      begin
         case (off)
            6'd0: m_dma[0] = d;
            6'd1: m_dma[1] = d;
            6'd2: m_dma[2] = d;
            6'd3: m_dma[3] = d;
            6'd4: m_dma[4] = d;
            default: ;
         endcase
      end
   endtask

   task automatic add_row(input string name, input logic wr, input logic [11:0] chip,
                          input logic [3:0] group, input logic [2:0] sel,
                          input logic [5:0] off, input logic bank, input logic acc,
                          input logic hold, input kind_t kind);
      logic [31:0] r;
      r = $urandom;
      rows[nrows].name = name;
      rows[nrows].pkt.write = wr;
      rows[nrows].pkt.datamode = r[1:0];
      rows[nrows].pkt.ctrlmode = r[5:2];
      rows[nrows].pkt.dstaddr = make_addr(chip, group, sel, off);
      rows[nrows].pkt.data = $urandom;
      rows[nrows].pkt.srcaddr = $urandom;
      rows[nrows].access = acc;
      rows[nrows].hold = hold;
      rows[nrows].kind = kind;
      rows[nrows].bank = bank;
      nrows++;
   endtask

   function automatic emesh_pkg::emesh_packet_t make_reply(input emesh_pkg::emesh_packet_t p,
                                                            input logic [31:0] d);
      make_reply = p;
      make_reply.write = 1'b1;
      make_reply.dstaddr = p.srcaddr;
      make_reply.srcaddr = p.dstaddr;
      make_reply.data = d;
   endfunction

   task automatic check_pkt(input string name, input emesh_pkg::emesh_packet_t exp_pkt);
      checks++;
      if (packet_out !== exp_pkt)
      begin
         errors++;
         $display("error %s: expected %h, actual %h", name, exp_pkt, packet_out);
      end
   endtask

   task automatic check_word(input string name, input logic [31:0] exp_v, input logic [31:0] act);
      checks++;
      if (act !== exp_v)
      begin
         errors++;
         $display("error %s: expected %h, actual %h", name, exp_v, act);
      end
   endtask

   // simulation watchdog
   initial
   begin
      #2000000;
      $display("simulation stopped by watchdog timeout");
      $display("ERRORS FOUND");
      $finish;
   end

   initial
   begin
      emesh_pkg::emesh_packet_t exp_pkt;
      emesh_pkg::emesh_packet_t held_pkt;
      logic                     held_acc;
      logic [5:0]               off;
      int                       n;
      int                       r;
      int                       seed;
      seed = 70;
      r = $urandom(seed);
      clk = 1'b0;
      nreset = 1'b0;
      access_in = 1'b0;
      wait_in = 1'b0;
      packet_in = '0;
      errors = 0;
      checks = 0;
      nrows = 0;
      m_cfg = 32'h0000_0010;
      m_gpio = 32'h0;
      for (int j = 0; j < 5; j++)
         m_dma[j] = 32'h0;

      // reads of untouched registers, then writes, then readback
      add_row("rd_dma_cfg_reset", 1'b0, 12'h810, 4'hf, 3'b101, 6'd0, 1'b1, 1, 0, k_reply);
      add_row("rd_cfg_reset", 1'b0, 12'h810, 4'hf, 3'b010, 6'd0, 1'b0, 1, 0, k_reply);
      add_row("wr_cfg", 1'b1, 12'h810, 4'hf, 3'b010, 6'd0, 1'b0, 1, 0, k_write);
      add_row("wr_gpio", 1'b1, 12'h810, 4'hf, 3'b010, 6'd2, 1'b0, 1, 0, k_write);
      for (int j = 0; j < 5; j++)
         add_row($sformatf("wr_dma_%0d", j), 1'b1, 12'h810, 4'hf, 3'b101, 6'(j), 1'b1,
                 1, 0, k_write);
      add_row("rd_cfg", 1'b0, 12'h810, 4'hf, 3'b010, 6'd0, 1'b0, 1, 0, k_reply);
      add_row("rd_gpio", 1'b0, 12'h810, 4'hf, 3'b010, 6'd2, 1'b0, 1, 0, k_reply);
      add_row("rd_version", 1'b0, 12'h810, 4'hf, 3'b010, 6'd3, 1'b0, 1, 0, k_reply);
      add_row("rd_cfg_unmapped", 1'b0, 12'h810, 4'hf, 3'b010, 6'd5, 1'b0, 1, 0, k_reply);
      for (int j = 0; j < 5; j++)
         add_row($sformatf("rd_dma_%0d", j), 1'b0, 12'h810, 4'hf, 3'b101, 6'(j), 1'b1,
                 1, 0, k_reply);
      add_row("rd_dma_unmapped", 1'b0, 12'h810, 4'hf, 3'b101, 6'd6, 1'b1, 1, 0, k_reply);
      add_row("fwd_rr", 1'b1, 12'h810, 4'hd, 3'b010, 6'd0, 1'b0, 1, 0, k_forward);
      add_row("fwd_mmu", 1'b0, 12'h810, 4'he, 3'b101, 6'd1, 1'b0, 1, 0, k_forward);
      add_row("fwd_mmr_other", 1'b1, 12'h810, 4'hf, 3'b011, 6'd0, 1'b0, 1, 0, k_forward);
      add_row("drop_chip", 1'b0, 12'h123, 4'hf, 3'b010, 6'd0, 1'b0, 1, 0, k_drop);
      add_row("drop_group", 1'b0, 12'h810, 4'h1, 3'b010, 6'd0, 1'b0, 1, 0, k_drop);
      // output stage held by wait_in while a write goes through
      add_row("rd_before_hold", 1'b0, 12'h810, 4'hf, 3'b010, 6'd2, 1'b0, 1, 0, k_reply);
      add_row("wr_gpio_hold", 1'b1, 12'h810, 4'hf, 3'b010, 6'd2, 1'b0, 1, 1, k_write);
      add_row("idle_hold_a", 1'b0, 12'h810, 4'hf, 3'b010, 6'd2, 1'b0, 0, 1, k_drop);
      add_row("idle_hold_b", 1'b0, 12'h810, 4'hf, 3'b010, 6'd2, 1'b0, 0, 1, k_drop);
      add_row("rd_after_hold", 1'b0, 12'h810, 4'hf, 3'b010, 6'd2, 1'b0, 1, 0, k_reply);

      repeat (10) @(negedge clk);
      nreset = 1'b1;
      @(negedge clk);
      check_word("reset_access_out", 32'h0, {31'h0, access_out});
      check_word("reset_etx_cfg", 32'h0000_0010, etx_cfg.cfg);
      check_word("reset_dma_cfg", 32'h0, dma_cfg.cfg | dma_cfg.count | dma_cfg.stride
                 | dma_cfg.srcaddr | dma_cfg.dstaddr);
      held_acc = access_out;
      held_pkt = packet_out;

      for (int i = 0; i < nrows; i++)
      begin
         off = rows[i].pkt.dstaddr[7:2];
         packet_in = rows[i].pkt;
         access_in = rows[i].access;
         wait_in = rows[i].hold;
         exp_pkt = rows[i].pkt;
         if (rows[i].kind == k_reply)
            exp_pkt = make_reply(rows[i].pkt, model_read(rows[i].bank, off));
         if (rows[i].kind == k_write)
            model_write(rows[i].bank, off, rows[i].pkt.data);
         @(negedge clk);
         access_in = 1'b0;
         if (rows[i].hold)
         begin
            check_word({rows[i].name, "_held_access"}, {31'h0, held_acc}, {31'h0, access_out});
            check_pkt({rows[i].name, "_held_packet"}, held_pkt);
         end
         else if (rows[i].kind == k_reply || rows[i].kind == k_forward)
         begin
            n = 0;
            while (!access_out && n < 4)
            begin
               @(negedge clk);
               n++;
            end
            checks++;
            if (!access_out)
            begin
               errors++;
               $display("%s: no output packet arrived before the timeout", rows[i].name);
            end
            else
               check_pkt(rows[i].name, exp_pkt);
         end
         else
            check_word({rows[i].name, "_access_out"}, 32'h0, {31'h0, access_out});
         if (rows[i].kind == k_write)
         begin
            check_word({rows[i].name, "_etx_cfg"}, m_cfg, etx_cfg.cfg);
            check_word({rows[i].name, "_etx_gpio"}, m_gpio, etx_cfg.gpio);
            check_word({rows[i].name, "_dma_cfg"}, m_dma[0], dma_cfg.cfg);
            check_word({rows[i].name, "_dma_count"}, m_dma[1], dma_cfg.count);
            check_word({rows[i].name, "_dma_stride"}, m_dma[2], dma_cfg.stride);
            check_word({rows[i].name, "_dma_srcaddr"}, m_dma[3], dma_cfg.srcaddr);
            check_word({rows[i].name, "_dma_dstaddr"}, m_dma[4], dma_cfg.dstaddr);
         end
         held_acc = access_out;
         held_pkt = packet_out;
      end
      wait_in = 1'b0;

      // back to back reads, alternating banks, one reply per cycle
      for (int k = 0; k < 6; k++)
      begin
         packet_in.write = 1'b0;
         packet_in.srcaddr = $urandom;
         off = 6'(k % 3);
         if (k % 2 == 0)
            packet_in.dstaddr = make_addr(12'h810, 4'hf, 3'b010, 6'd2);
         else
            packet_in.dstaddr = make_addr(12'h810, 4'hf, 3'b101, off);
         access_in = 1'b1;
         exp_pkt = make_reply(packet_in, (k % 2 == 0) ? m_gpio : model_read(1'b1, off));
         @(negedge clk);
         checks++;
         if (!access_out)
         begin
            errors++;
            $display("burst read %0d produced no reply", k);
         end
         check_pkt($sformatf("burst_rd_%0d", k), exp_pkt);
      end
      access_in = 1'b0;
      @(negedge clk);

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire

/* project.f */
emesh_pkg.sv
ecfg_map_pkg.sv
ecfg_if.sv
ecfg_cfg_regs.sv
ecfg_dma_regs.sv
elink_cfg_top.sv
elink_cfg_asserts.sv
tb_elink_cfg.sv

/* Makefile */
# Verilator build and run for the link config port testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert --top-module tb_elink_cfg -f project.f
	./obj_dir/Vtb_elink_cfg > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "ERRORS FOUND" sim.log; then \
		echo "test failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
